//--- ksa_consts.svh
`ifndef KSA_CONSTS_SVH
`define KSA_CONSTS_SVH

// Datapath and register address widths
`define KSA_WIDTH      32
`define KSA_ADDR_W     5

// Register byte offsets
`define KSA_REG_OPA    5'h00
`define KSA_REG_OPB    5'h04
`define KSA_REG_CTRL   5'h08
`define KSA_REG_RESULT 5'h0C
`define KSA_REG_STATUS 5'h10

// CTRL bit positions
`define KSA_CTRL_GO    0
`define KSA_CTRL_SUB   1
`define KSA_CTRL_CIN   2

// STATUS bit positions
`define KSA_STAT_DONE  0
`define KSA_STAT_COUT  1
`define KSA_STAT_OVF   2
`define KSA_STAT_ZERO  3

`endif

//--- ksa_types_pkg.sv
`include "ksa_consts.svh"

package ksa_types_pkg;

    // Operand and result word
    typedef logic [`KSA_WIDTH-1:0] operand_t;

    // Result flags, packed as {zero, ovf, cout}
    typedef logic [2:0] flags_t;

    localparam int FLAG_COUT = 0;
    localparam int FLAG_OVF  = 1;
    localparam int FLAG_ZERO = 2;

    // Add unit pipeline occupancy
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        ONE   = 2'd1,
        TWO   = 2'd2
    } stage_t;

endpackage

//--- axil_pkg.sv
`include "ksa_consts.svh"

package axil_pkg;

    typedef logic [`KSA_ADDR_W-1:0] axil_addr_t;
    typedef logic [31:0]            axil_data_t;
    typedef logic [1:0]             axil_resp_t;

    // Response codes
    localparam axil_resp_t OKAY   = 2'b00;
    localparam axil_resp_t SLVERR = 2'b10;

endpackage

//--- add_op_if.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

interface add_op_if;

    // Request, register block to add unit
    logic                    start;
    ksa_types_pkg::operand_t a;
    ksa_types_pkg::operand_t b;
    logic                    sub;
    logic                    cin;

    // Response, add unit to register block
    logic                    done;
    ksa_types_pkg::operand_t sum;
    ksa_types_pkg::flags_t   flags;

    modport regs (
        output start,
        output a,
        output b,
        output sub,
        output cin,
        input  done,
        input  sum,
        input  flags
    );

    modport unit (
        input  start,
        input  a,
        input  b,
        input  sub,
        input  cin,
        output done,
        output sum,
        output flags
    );

endinterface

//--- ksa_prefix_adder.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

module ksa_prefix_adder #(
    parameter int WIDTH = `KSA_WIDTH
) (
    input  ksa_types_pkg::operand_t a,
    input  ksa_types_pkg::operand_t b,
    input  logic                    cin,
    output ksa_types_pkg::operand_t sum,
    output logic                    cout
);

    // One prefix row per doubling of the span
    localparam int LEVELS = $clog2(WIDTH);

    // Bit 0 of p/g holds the carry-in, operand bits sit one place up
    logic [WIDTH:0] p;
    logic [WIDTH:0] g;

    // Group generate and propagate after each row
    wire [WIDTH-1:0] gr [0:LEVELS];
    wire [WIDTH-1:0] pr [0:LEVELS];

    // Grey cell, group generate only
    function automatic logic grey_cell(
        input logic g_hi,
        input logic p_hi,
        input logic g_lo
    );
        return g_hi | (p_hi & g_lo);
    endfunction

    // Black cell, returns {g, p}
    function automatic logic [1:0] black_cell(
        input logic g_hi,
        input logic p_hi,
        input logic g_lo,
        input logic p_lo
    );
        return {g_hi | (p_hi & g_lo), p_hi & p_lo};
    endfunction

    //////////////////////////////////////////////////
    // Propagate / generate stage
    //////////////////////////////////////////////////

    assign p[0] = 1'b0;
    assign g[0] = cin;

    genvar i;
    genvar r;

    generate
        for (i = 1; i <= WIDTH; i = i + 1) begin : g_pg
            assign p[i] = a[i-1] ^ b[i-1];
            assign g[i] = a[i-1] & b[i-1];
        end
    endgenerate

    assign gr[0] = g[WIDTH-1:0];
    assign pr[0] = p[WIDTH-1:0];

    //////////////////////////////////////////////////
    // Prefix rows
    //////////////////////////////////////////////////

    generate
        for (r = 0; r < LEVELS; r = r + 1) begin : g_row
            localparam int SPAN = 1 << r;
            for (i = 0; i < WIDTH; i = i + 1) begin : g_col
                if (i < SPAN) begin : g_copy
                    // Prefix already reaches bit 0
                    assign gr[r+1][i] = gr[r][i];
                    assign pr[r+1][i] = 1'b0;
                end else if (i < 2 * SPAN) begin : g_grey
                    // Lower group is complete, so this one closes here
                    assign gr[r+1][i] = grey_cell(gr[r][i], pr[r][i], gr[r][i-SPAN]);
                    assign pr[r+1][i] = 1'b0;
                end else begin : g_black
                    assign {gr[r+1][i], pr[r+1][i]} =
                        black_cell(gr[r][i], pr[r][i], gr[r][i-SPAN], pr[r][i-SPAN]);
                end
            end
        end
    endgenerate

    //////////////////////////////////////////////////
    // Sum stage
    //////////////////////////////////////////////////

    // gr[LEVELS][i] is the carry into operand bit i
    generate
        for (i = 0; i < WIDTH; i = i + 1) begin : g_sum
            assign sum[i] = p[i+1] ^ gr[LEVELS][i];
        end
    endgenerate

    assign cout = grey_cell(g[WIDTH], p[WIDTH], gr[LEVELS][WIDTH-1]);

endmodule

//--- ksa_add_unit.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

module ksa_add_unit (
    input logic clk,
    input logic rst,
    add_op_if.unit op
);

    // Stage 1, operands with subtract already folded in
    logic                    s1_valid;
    ksa_types_pkg::operand_t s1_a;
    ksa_types_pkg::operand_t s1_b;
    logic                    s1_cin;

    // Stage 2, registered result
    logic                    s2_valid;
    ksa_types_pkg::operand_t s2_sum;
    ksa_types_pkg::flags_t   s2_flags;

    ksa_types_pkg::operand_t add_sum;
    logic                    add_cout;
    ksa_types_pkg::stage_t   occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= op.start;
            s2_valid <= s1_valid;
        end
    end

    // A - B - cin computed as A + ~B + ~cin
    always_ff @(posedge clk) begin
        if (op.start) begin
            s1_a   <= op.a;
            s1_b   <= op.sub ? ~op.b : op.b;
            s1_cin <= op.sub ? ~op.cin : op.cin;
        end
    end

    ksa_prefix_adder #(
        .WIDTH (`KSA_WIDTH)
    ) u_adder (
        .a    (s1_a),
        .b    (s1_b),
        .cin  (s1_cin),
        .sum  (add_sum),
        .cout (add_cout)
    );

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_sum                                <= add_sum;
            s2_flags[ksa_types_pkg::FLAG_COUT]    <= add_cout;
            // Same input signs, different result sign
            s2_flags[ksa_types_pkg::FLAG_OVF]     <=
                (s1_a[`KSA_WIDTH-1] == s1_b[`KSA_WIDTH-1]) &&
                (add_sum[`KSA_WIDTH-1] != s1_a[`KSA_WIDTH-1]);
            s2_flags[ksa_types_pkg::FLAG_ZERO]    <= (add_sum == '0);
        end
    end

    // Operations in flight after this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= ksa_types_pkg::EMPTY;
        end else begin
            case ({op.start, s1_valid})
                2'b00:   occ <= ksa_types_pkg::EMPTY;
                2'b11:   occ <= ksa_types_pkg::TWO;
                default: occ <= ksa_types_pkg::ONE;
            endcase
        end
    end

    assign op.done  = s2_valid;
    assign op.sum   = s2_sum;
    assign op.flags = s2_flags;

endmodule

//--- ksa_axil_regs.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

module ksa_axil_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  axil_pkg::axil_addr_t   awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  axil_pkg::axil_data_t   wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output axil_pkg::axil_resp_t   bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  axil_pkg::axil_addr_t   araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output axil_pkg::axil_data_t   rdata,
    output axil_pkg::axil_resp_t   rresp,
    output logic                   rvalid,
    input  logic                   rready,
    add_op_if.regs                 op
);

    ksa_types_pkg::operand_t opa_q;
    ksa_types_pkg::operand_t opb_q;
    logic                    sub_q;
    logic                    cin_q;
    logic                    start_q;
    ksa_types_pkg::operand_t result_q;
    ksa_types_pkg::flags_t   flags_q;
    logic                    done_q;

    logic                    wr_hs;
    logic                    wr_err;
    logic                    rd_err;
    axil_pkg::axil_data_t    rd_word;
    axil_pkg::axil_data_t    ctrl_word;
    axil_pkg::axil_data_t    status_word;

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////

    assign wready = awready;
    assign wr_hs  = awvalid && awready && wvalid && wready;

    // Only operands and control are writable
    always_comb begin
        case (awaddr)
            `KSA_REG_OPA, `KSA_REG_OPB, `KSA_REG_CTRL: wr_err = 1'b0;
            default:                                   wr_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready  <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= axil_pkg::OKAY;
            opa_q    <= '0;
            opb_q    <= '0;
            sub_q    <= 1'b0;
            cin_q    <= 1'b0;
            start_q  <= 1'b0;
            result_q <= '0;
            flags_q  <= '0;
            done_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            // One-cycle ready once both AW and W are up
            awready <= awvalid && wvalid && !bvalid && !awready;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (op.done) begin
                result_q <= op.sum;
                flags_q  <= op.flags;
                done_q   <= 1'b1;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? axil_pkg::SLVERR : axil_pkg::OKAY;
                case (awaddr)
                    `KSA_REG_OPA: opa_q <= wdata;
                    `KSA_REG_OPB: opb_q <= wdata;
                    `KSA_REG_CTRL: begin
                        sub_q   <= wdata[`KSA_CTRL_SUB];
                        cin_q   <= wdata[`KSA_CTRL_CIN];
                        start_q <= wdata[`KSA_CTRL_GO];
                        // New command, old result no longer current
                        done_q  <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////

    always_comb begin
        ctrl_word                        = '0;
        ctrl_word[`KSA_CTRL_SUB]         = sub_q;
        ctrl_word[`KSA_CTRL_CIN]         = cin_q;
        status_word                      = '0;
        status_word[`KSA_STAT_DONE]      = done_q;
        status_word[`KSA_STAT_COUT]      = flags_q[ksa_types_pkg::FLAG_COUT];
        status_word[`KSA_STAT_OVF]       = flags_q[ksa_types_pkg::FLAG_OVF];
        status_word[`KSA_STAT_ZERO]      = flags_q[ksa_types_pkg::FLAG_ZERO];
    end

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            `KSA_REG_OPA:    rd_word = opa_q;
            `KSA_REG_OPB:    rd_word = opb_q;
            `KSA_REG_CTRL:   rd_word = ctrl_word;
            `KSA_REG_RESULT: rd_word = result_q;
            `KSA_REG_STATUS: rd_word = status_word;
            default:         rd_err  = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= axil_pkg::OKAY;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            // rdata only moves on a new address handshake
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rdata  <= rd_word;
                rresp  <= rd_err ? axil_pkg::SLVERR : axil_pkg::OKAY;
            end
        end
    end

    assign op.start = start_q;
    assign op.a     = opa_q;
    assign op.b     = opb_q;
    assign op.sub   = sub_q;
    assign op.cin   = cin_q;

endmodule

//--- ksa_accel_top.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

module ksa_accel_top (
    input  logic                 clk,
    input  logic                 rst,
    input  axil_pkg::axil_addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  axil_pkg::axil_data_t wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output axil_pkg::axil_resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  axil_pkg::axil_addr_t araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output axil_pkg::axil_data_t rdata,
    output axil_pkg::axil_resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready
);

    // Request/result path between registers and adder
    add_op_if op_bus ();

    ksa_axil_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .op      (op_bus.regs)
    );

    ksa_add_unit u_unit (
        .clk (clk),
        .rst (rst),
        .op  (op_bus.unit)
    );

endmodule

//--- ksa_accel_sva.sv
`timescale 1ns/1ps

module ksa_accel_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  bvalid,
    input logic                  bready,
    input logic                  rvalid,
    input logic                  rready,
    input axil_pkg::axil_data_t  rdata,
    input logic                  start,
    input logic                  done,
    input ksa_types_pkg::stage_t occ
);

    //////////////////////////////////////////////////
    // AXI4-Lite response channels
    //////////////////////////////////////////////////

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Read data must not move while the master stalls
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    //////////////////////////////////////////////////
    // Add unit pipeline
    //////////////////////////////////////////////////

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        start |-> ##2 done)
        else $error("done did not follow start by 2 cycles");

    a_done_source: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(start, 2))
        else $error("done without a start 2 cycles earlier");

    // Operations in flight are the starts of the last two cycles
    a_occ_count: assert property (@(posedge clk) disable iff (rst)
        occ == 2'($past(start)) + 2'($past(start, 2)))
        else $error("pipeline occupancy does not match starts in flight");

endmodule

bind ksa_accel_top ksa_accel_sva u_sva (
    .clk    (clk),
    .rst    (rst),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .start  (op_bus.start),
    .done   (op_bus.done),
    .occ    (u_unit.occ)
);

//--- tb_ksa_accel.sv
`timescale 1ns/1ps
`include "ksa_consts.svh"

module tb_ksa_accel;

    localparam int TIMEOUT = 40;

    logic                 clk, rst;
    axil_pkg::axil_addr_t awaddr, araddr;
    axil_pkg::axil_data_t wdata, rdata;
    axil_pkg::axil_resp_t bresp, rresp;
    logic                 awvalid, awready, wvalid, wready, bvalid, bready;
    logic                 arvalid, arready, rvalid, rready;

    int     errors;
    int     checks;
    int     tests;
    integer seed;

    ksa_accel_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout: no %s within %0d cycles at t=%0t", what, TIMEOUT, $time);
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master tasks
    //////////////////////////////////////////////////

    task automatic axil_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                              input int hold, output axil_pkg::axil_resp_t resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        // awready seen here means acceptance on the next rising edge
        while (!awready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!awready) begin
            report_timeout("awready");
        end else begin
            check(wready, 1'b1, "wready together with awready");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Address and data move away once accepted
        awaddr  = ~addr;
        wdata   = ~data;
        check(awready, 1'b0, "awready one cycle wide");
        check(wready, 1'b0, "wready one cycle wide");
        n = 0;
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) report_timeout("bvalid");
        resp = bresp;
        repeat (hold) begin
            @(negedge clk);
            check(bvalid, 1'b1, "bvalid held under back-pressure");
            check(bresp, resp, "bresp stable under back-pressure");
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_pkg::axil_addr_t addr, input int hold,
                             output axil_pkg::axil_data_t data, output axil_pkg::axil_resp_t resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) report_timeout("arready");
        @(negedge clk);
        arvalid = 1'b0;
        // Address moves away once accepted
        araddr  = ~addr;
        check(arready, 1'b0, "arready one cycle wide");
        n = 0;
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) report_timeout("rvalid");
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check(rvalid, 1'b1, "rvalid held under back-pressure");
            check(rdata, data, "rdata stable under back-pressure");
            check(rresp, resp, "rresp stable under back-pressure");
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_reg(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data);
        axil_pkg::axil_resp_t resp;
        axil_write(addr, data, 0, resp);
        check(resp, axil_pkg::OKAY, $sformatf("bresp for write to %h", addr));
    endtask

    task automatic read_reg(input axil_pkg::axil_addr_t addr, output axil_pkg::axil_data_t data);
        axil_pkg::axil_resp_t resp;
        axil_read(addr, 0, data, resp);
        check(resp, axil_pkg::OKAY, $sformatf("rresp for read from %h", addr));
    endtask

    //////////////////////////////////////////////////
    // Reference model and operation runner
    //////////////////////////////////////////////////

    task automatic predict(input logic [31:0] a, input logic [31:0] b, input logic sub,
                           input logic cin, output logic [31:0] res, output logic [31:0] stat);
        logic [33:0] wide;
        logic        cout;
        logic        ovf;
        // Exact signed result in 34 bits
        if (sub) begin
            wide = {{2{a[31]}}, a} - {{2{b[31]}}, b} - cin;
            // No borrow out means carry set
            cout = ({1'b0, a} >= ({1'b0, b} + cin));
        end else begin
            wide = {{2{a[31]}}, a} + {{2{b[31]}}, b} + cin;
            cout = (({1'b0, a} + {1'b0, b} + cin) > 33'h0FFFFFFFF);
        end
        res = wide[31:0];
        ovf = (wide[33:31] != 3'b000) && (wide[33:31] != 3'b111);
        stat = '0;
        stat[`KSA_STAT_DONE] = 1'b1;
        stat[`KSA_STAT_COUT] = cout;
        stat[`KSA_STAT_OVF]  = ovf;
        stat[`KSA_STAT_ZERO] = (res == 32'h0);
    endtask

    task automatic wait_done(output logic [31:0] stat);
        int polls;
        polls = 0;
        read_reg(`KSA_REG_STATUS, stat);
        while (!stat[`KSA_STAT_DONE] && polls < 8) begin
            read_reg(`KSA_REG_STATUS, stat);
            polls++;
        end
        if (!stat[`KSA_STAT_DONE]) report_timeout("DONE bit in STATUS");
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
                          input logic cin);
        logic [31:0] exp_res;
        logic [31:0] exp_stat;
        logic [31:0] got;
        string       tag;
        predict(a, b, sub, cin, exp_res, exp_stat);
        tag = $sformatf("%s %h,%h cin=%0b", sub ? "sub" : "add", a, b, cin);
        write_reg(`KSA_REG_OPA, a);
        write_reg(`KSA_REG_OPB, b);
        write_reg(`KSA_REG_CTRL, (32'(cin) << `KSA_CTRL_CIN) | (32'(sub) << `KSA_CTRL_SUB) |
                                 (32'd1 << `KSA_CTRL_GO));
        wait_done(got);
        check(got, exp_stat, {tag, " status"});
        read_reg(`KSA_REG_RESULT, got);
        check(got, exp_res, {tag, " result"});
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("[%0t] %s finished with %0d errors", $time, name, errors - errors_before);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic access_registers();
        int          e0;
        logic [31:0] got;
        logic [31:0] va;
        logic [31:0] vb;
        e0 = errors;
        // Everything is zero out of reset
        read_reg(`KSA_REG_OPA, got);
        check(got, 32'h0, "OPA after reset");
        read_reg(`KSA_REG_OPB, got);
        check(got, 32'h0, "OPB after reset");
        read_reg(`KSA_REG_CTRL, got);
        check(got, 32'h0, "CTRL after reset");
        read_reg(`KSA_REG_RESULT, got);
        check(got, 32'h0, "RESULT after reset");
        read_reg(`KSA_REG_STATUS, got);
        check(got, 32'h0, "STATUS after reset");
        va = $random(seed);
        vb = $random(seed);
        write_reg(`KSA_REG_OPA, va);
        write_reg(`KSA_REG_OPB, vb);
        read_reg(`KSA_REG_OPA, got);
        check(got, va, "OPA readback");
        read_reg(`KSA_REG_OPB, got);
        check(got, vb, "OPB readback");
        finish_test("register access", e0);
    endtask

    task automatic add_operands();
        int          e0;
        logic [31:0] a;
        logic [31:0] b;
        logic        cin;
        e0 = errors;
        run_op(32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
        run_op(32'hFFFF_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'h0000_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'h7FFF_FFFF, 32'h0000_0001, 1'b0, 1'b0);
        run_op(32'hFFFF_FFFF, 32'h0000_0000, 1'b0, 1'b1);
        run_op(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 1'b1);
        run_op(32'h5555_5555, 32'hAAAA_AAAA, 1'b0, 1'b1);
        repeat (20) begin
            a = $random(seed);
            b = $random(seed);
            cin = $random(seed);
            run_op(a, b, 1'b0, cin);
        end
        finish_test("addition", e0);
    endtask

    task automatic subtract_operands();
        int          e0;
        logic [31:0] a;
        e0 = errors;
        a = $random(seed);
        run_op(a, a, 1'b1, 1'b0);
        run_op(32'h8000_0000, 32'h0000_0001, 1'b1, 1'b0);
        run_op(32'h7FFF_FFFF, 32'hFFFF_FFFF, 1'b1, 1'b0);
        // Borrow-in cases
        run_op(32'h0000_0005, 32'h0000_0003, 1'b1, 1'b1);
        run_op(32'h0000_0000, 32'h0000_0000, 1'b1, 1'b1);
        run_op(32'h8000_0000, 32'h0000_0000, 1'b1, 1'b1);
        finish_test("subtraction", e0);
    endtask

    task automatic provoke_errors();
        int                   e0;
        logic [31:0]          got;
        logic [31:0]          exp_res;
        logic [31:0]          exp_stat;
        axil_pkg::axil_resp_t resp;
        e0 = errors;
        // Known result and flags to compare against afterwards
        predict(32'h1234_5678, 32'h9ABC_DEF0, 1'b0, 1'b0, exp_res, exp_stat);
        run_op(32'h1234_5678, 32'h9ABC_DEF0, 1'b0, 1'b0);
        axil_write(`KSA_REG_RESULT, 32'hDEAD_BEEF, 0, resp);
        check(resp, axil_pkg::SLVERR, "bresp for write to RESULT");
        axil_write(5'h14, 32'hCAFE_F00D, 0, resp);
        check(resp, axil_pkg::SLVERR, "bresp for write to unmapped 0x14");
        axil_read(5'h1C, 0, got, resp);
        check(resp, axil_pkg::SLVERR, "rresp for read from unmapped 0x1C");
        check(got, 32'h0, "rdata for unmapped read");
        read_reg(`KSA_REG_OPA, got);
        check(got, 32'h1234_5678, "OPA after error accesses");
        read_reg(`KSA_REG_OPB, got);
        check(got, 32'h9ABC_DEF0, "OPB after error accesses");
        read_reg(`KSA_REG_CTRL, got);
        check(got, 32'h0, "CTRL after error accesses");
        read_reg(`KSA_REG_RESULT, got);
        check(got, exp_res, "RESULT after error accesses");
        read_reg(`KSA_REG_STATUS, got);
        check(got, exp_stat, "STATUS after error accesses");
        finish_test("error responses", e0);
    endtask

    task automatic stall_responses();
        int                   e0;
        logic [31:0]          got;
        logic [31:0]          exp_res;
        logic [31:0]          exp_stat;
        axil_pkg::axil_resp_t resp;
        e0 = errors;
        // Stability is checked inside the bus tasks while ready stays low
        axil_write(`KSA_REG_OPA, 32'h0F0F_0F0F, 6, resp);
        check(resp, axil_pkg::OKAY, "bresp after held write");
        axil_read(`KSA_REG_OPA, 6, got, resp);
        check(resp, axil_pkg::OKAY, "rresp after held read");
        check(got, 32'h0F0F_0F0F, "rdata after held read");
        // Two GO writes back to back, second result must win
        write_reg(`KSA_REG_OPB, 32'h0000_0011);
        write_reg(`KSA_REG_CTRL, 32'd1 << `KSA_CTRL_GO);
        write_reg(`KSA_REG_OPA, 32'h8000_0000);
        write_reg(`KSA_REG_OPB, 32'h8000_0000);
        write_reg(`KSA_REG_CTRL, 32'd1 << `KSA_CTRL_GO);
        predict(32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0, exp_res, exp_stat);
        wait_done(got);
        check(got, exp_stat, "STATUS after second GO");
        read_reg(`KSA_REG_RESULT, got);
        check(got, exp_res, "RESULT after second GO");
        finish_test("back-pressure", e0);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        tests   = 0;
        seed    = 81;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        access_registers();
        add_operands();
        subtract_operands();
        provoke_errors();
        stall_responses();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
ksa_types_pkg.sv
axil_pkg.sv
add_op_if.sv
ksa_prefix_adder.sv
ksa_add_unit.sv
ksa_axil_regs.sv
ksa_accel_top.sv
ksa_accel_sva.sv
tb_ksa_accel.sv

//--- Bender.yml
package:
  name: ksa_accel

sources:
  - include_dirs:
      - .
    files:
      - ksa_types_pkg.sv
      - axil_pkg.sv
      - add_op_if.sv
      - ksa_prefix_adder.sv
      - ksa_add_unit.sv
      - ksa_axil_regs.sv
      - ksa_accel_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ksa_accel_sva.sv
      - tb_ksa_accel.sv
